/* hdl/frontend_pkg.sv */
// ====================
// shared types for the in-order front end (fetch, buffer, decode)
// instruction lines are 128 bits, slot 0 in the low word
// decoder covers a small RV32I subset, anything else is op_illegal
// ====================

`default_nettype none

package frontend_pkg;

  localparam int XLEN        = 32;
  localparam int FETCH_WIDTH = 4;
  localparam int LINE_BITS   = FETCH_WIDTH * XLEN;
  localparam int LINE_BYTES  = LINE_BITS / 8;

  // RV32I major opcodes handled by the decoder
  typedef enum logic [6:0] {
    opc_load   = 7'b000_0011,
    opc_op_imm = 7'b001_0011,
    opc_store  = 7'b010_0011,
    opc_op     = 7'b011_0011,
    opc_lui    = 7'b011_0111,
    opc_branch = 7'b110_0011,
    opc_jal    = 7'b110_1111
  } rv_opcode_t;

  // funct7 values for register ALU ops
  localparam logic [6:0] FUNCT7_BASE = 7'b000_0000;
  localparam logic [6:0] FUNCT7_ALT  = 7'b010_0000;

  // micro-op kinds
  typedef enum logic [3:0] {
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_slt,
    op_addi,
    op_lui,
    op_load,
    op_store,
    op_branch,
    op_jal,
    op_illegal
  } uop_opcode_t;

  // one fetched instruction
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] inst;
  } fetch_entry_t;

  // one decoded instruction
  // register index fields always carry the raw instruction bits
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    uop_opcode_t     opcode;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic            rs1_valid;
    logic            rs2_valid;
    logic            rd_valid;
    logic [XLEN-1:0] imm;
  } micro_op_t;

  // restart request from outside
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
  } redirect_t;

endpackage

`default_nettype wire

/* hdl/inst_fetch.sv */
// ====================
// one outstanding line request, address held until icache_valid
// redirect pc must be word aligned, it may sit mid-line
// a response is dropped when the buffer has no room for a line
// ====================

`default_nettype none

module inst_fetch #(
  parameter logic [frontend_pkg::XLEN-1:0] RESET_PC = 32'h0000_1000
) (
  input  logic                                                  clock,
  input  logic                                                  reset,
  input  frontend_pkg::redirect_t                               redirect,
  input  logic [frontend_pkg::LINE_BITS-1:0]                    icache_data,
  input  logic                                                  icache_valid,
  input  logic                                                  room,
  output logic [frontend_pkg::XLEN-1:0]                         icache_addr,
  output frontend_pkg::fetch_entry_t [frontend_pkg::FETCH_WIDTH-1:0] packet,
  output logic                                                  packet_write
);

  import frontend_pkg::*;

  localparam int SLOT_W = $clog2(FETCH_WIDTH);
  localparam int OFS_W  = $clog2(LINE_BYTES);

  logic [XLEN-1:0]   pc;
  logic [XLEN-1:0]   line_addr;
  logic [SLOT_W-1:0] word_ofs;
  logic              accept;

  assign line_addr = {pc[XLEN-1:OFS_W], {OFS_W{1'b0}}};
  assign word_ofs  = pc[OFS_W-1:2];
  assign accept    = icache_valid && room;

  assign icache_addr = line_addr;

  // slots below the entry word are skipped
  always_comb begin
    for (int i = 0; i < FETCH_WIDTH; i++) begin
      packet[i].valid = icache_valid && (SLOT_W'(i) >= word_ofs);
      packet[i].pc    = line_addr + XLEN'(4 * i);
      packet[i].inst  = icache_data[i*XLEN +: XLEN];
    end
  end

  // response at a redirect edge belongs to the old path
  assign packet_write = accept && !redirect.valid;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= RESET_PC;
    end else if (redirect.valid) begin
      pc <= redirect.pc;
    end else if (accept) begin
      // next line starts at slot 0
      pc <= line_addr + XLEN'(LINE_BYTES);
    end
  end

endmodule

`default_nettype wire

/* hdl/fetch_buffer.sv */
// ====================
// circular queue, FB_DEPTH a power of two of at least 8
// room means a whole line of FETCH_WIDTH fits
// flush drops every entry in the same edge
// ====================

`default_nettype none

module fetch_buffer #(
  parameter int DECODE_WIDTH = 2,
  parameter int FB_DEPTH     = 16
) (
  input  logic                                                  clock,
  input  logic                                                  reset,
  input  logic                                                  flush,
  input  frontend_pkg::fetch_entry_t [frontend_pkg::FETCH_WIDTH-1:0] packet,
  input  logic                                                  packet_write,
  input  logic                                                  advance,
  output logic                                                  room,
  output frontend_pkg::fetch_entry_t [DECODE_WIDTH-1:0]         window
);

  import frontend_pkg::*;

  localparam int PTR_W = $clog2(FB_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  fetch_entry_t     entries [FB_DEPTH];
  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] n_in;
  logic [CNT_W-1:0] n_out;
  logic [PTR_W-1:0] slot_ofs [FETCH_WIDTH];

  // compaction: each valid slot lands after the valid slots before it
  always_comb begin
    n_in = '0;
    for (int i = 0; i < FETCH_WIDTH; i++) begin
      slot_ofs[i] = n_in[PTR_W-1:0];
      if (packet_write && packet[i].valid) begin
        n_in = n_in + 1'b1;
      end
    end
  end

  // head window, valid for every entry present
  always_comb begin
    n_out = '0;
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      window[i]       = entries[head + PTR_W'(i)];
      window[i].valid = CNT_W'(i) < count;
      if (advance && window[i].valid) begin
        n_out = n_out + 1'b1;
      end
    end
  end

  assign room = (CNT_W'(FB_DEPTH) - count) >= CNT_W'(FETCH_WIDTH);

  always_ff @(posedge clock) begin
    for (int i = 0; i < FETCH_WIDTH; i++) begin
      if (packet_write && packet[i].valid) begin
        entries[tail + slot_ofs[i]] <= packet[i];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      head  <= head + n_out[PTR_W-1:0];
      tail  <= tail + n_in[PTR_W-1:0];
      count <= count + n_in - n_out;
    end
  end

  // fetch has to honour the room check
  a_no_overrun: assert property (@(posedge clock) disable iff (reset)
    packet_write |-> room);

  a_count_bound: assert property (@(posedge clock) disable iff (reset)
    count <= CNT_W'(FB_DEPTH));

endmodule

`default_nettype wire

/* hdl/inst_decode.sv */
// ====================
// registered decode, one uop per window lane
// uops hold while stall is high, flush clears them
// ====================

`default_nettype none

module inst_decode #(
  parameter int DECODE_WIDTH = 2
) (
  input  logic                                          clock,
  input  logic                                          reset,
  input  logic                                          flush,
  input  logic                                          stall,
  input  frontend_pkg::fetch_entry_t [DECODE_WIDTH-1:0] window,
  output logic                                          advance,
  output frontend_pkg::micro_op_t [DECODE_WIDTH-1:0]    uops
);

  import frontend_pkg::*;

  logic [DECODE_WIDTH-1:0] lane_valid;

  function automatic micro_op_t decode_inst(input fetch_entry_t entry);
    micro_op_t       uop;
    logic [XLEN-1:0] inst;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic            rd_write;

    uop      = '0;
    inst     = entry.inst;
    funct3   = inst[14:12];
    funct7   = inst[31:25];
    rd_write = 1'b0;
    imm_i    = {{20{inst[31]}}, inst[31:20]};
    imm_s    = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    imm_b    = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_u    = {inst[31:12], 12'b0};
    imm_j    = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    if (entry.valid) begin
      uop.valid  = 1'b1;
      uop.pc     = entry.pc;
      uop.rs1    = inst[19:15];
      uop.rs2    = inst[24:20];
      uop.rd     = inst[11:7];
      uop.opcode = op_illegal;

      case (inst[6:0])
        opc_op: begin
          if (funct7 == FUNCT7_BASE) begin
            case (funct3)
              3'b000:  uop.opcode = op_add;
              3'b010:  uop.opcode = op_slt;
              3'b100:  uop.opcode = op_xor;
              3'b110:  uop.opcode = op_or;
              3'b111:  uop.opcode = op_and;
              default: uop.opcode = op_illegal;
            endcase
          end else if (funct7 == FUNCT7_ALT && funct3 == 3'b000) begin
            uop.opcode = op_sub;
          end
        end
        opc_op_imm: if (funct3 == 3'b000) uop.opcode = op_addi;
        opc_lui:    uop.opcode = op_lui;
        opc_load:   if (funct3 == 3'b010) uop.opcode = op_load;
        opc_store:  if (funct3 == 3'b010) uop.opcode = op_store;
        // 010 and 011 are not branch conditions
        opc_branch: if (funct3[2:1] != 2'b01) uop.opcode = op_branch;
        opc_jal:    uop.opcode = op_jal;
        default:    uop.opcode = op_illegal;
      endcase

      // operand usage by format
      case (uop.opcode)
        op_add, op_sub, op_and, op_or, op_xor, op_slt: begin
          uop.rs1_valid = 1'b1;
          uop.rs2_valid = 1'b1;
          rd_write      = 1'b1;
        end
        op_addi, op_load: begin
          uop.rs1_valid = 1'b1;
          uop.imm       = imm_i;
          rd_write      = 1'b1;
        end
        op_lui: begin
          uop.imm  = imm_u;
          rd_write = 1'b1;
        end
        op_store: begin
          uop.rs1_valid = 1'b1;
          uop.rs2_valid = 1'b1;
          uop.imm       = imm_s;
        end
        op_branch: begin
          uop.rs1_valid = 1'b1;
          uop.rs2_valid = 1'b1;
          uop.imm       = imm_b;
        end
        op_jal: begin
          uop.imm  = imm_j;
          rd_write = 1'b1;
        end
        default: uop.imm = '0;
      endcase

      // x0 is never a destination
      uop.rd_valid = rd_write && (uop.rd != 5'd0);
    end
    return uop;
  endfunction

  assign advance = !stall;

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      uops <= '0;
    end else if (advance) begin
      for (int i = 0; i < DECODE_WIDTH; i++) begin
        uops[i] <= decode_inst(window[i]);
      end
    end
  end

  always_comb begin
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      lane_valid[i] = uops[i].valid;
    end
  end

  // lanes fill from lane 0 with no holes, as the buffer window does
  a_lanes_packed: assert property (@(posedge clock) disable iff (reset)
    (lane_valid & (lane_valid + 1'b1)) == '0);

endmodule

`default_nettype wire

/* hdl/frontend.sv */
// ====================
// fetch, fetch buffer and decode in order
// redirect flushes all stages, stall holds uops
// ====================

`default_nettype none

module frontend #(
  parameter int                            DECODE_WIDTH = 2,
  parameter int                            FB_DEPTH     = 16,
  parameter logic [frontend_pkg::XLEN-1:0] RESET_PC     = 32'h0000_1000
) (
  input  logic                                       clock,
  input  logic                                       reset,
  input  frontend_pkg::redirect_t                    redirect,
  input  logic [frontend_pkg::LINE_BITS-1:0]         icache_data,
  input  logic                                       icache_valid,
  input  logic                                       stall,
  output logic [frontend_pkg::XLEN-1:0]              icache_addr,
  output frontend_pkg::micro_op_t [DECODE_WIDTH-1:0] uops
);

  import frontend_pkg::*;

  fetch_entry_t [FETCH_WIDTH-1:0]  packet;
  logic                            packet_write;
  logic                            room;
  fetch_entry_t [DECODE_WIDTH-1:0] window;
  logic                            advance;

  inst_fetch #(
    .RESET_PC (RESET_PC)
  ) fetch_i (
    .clock        (clock),
    .reset        (reset),
    .redirect     (redirect),
    .icache_data  (icache_data),
    .icache_valid (icache_valid),
    .room         (room),
    .icache_addr  (icache_addr),
    .packet       (packet),
    .packet_write (packet_write)
  );

  fetch_buffer #(
    .DECODE_WIDTH (DECODE_WIDTH),
    .FB_DEPTH     (FB_DEPTH)
  ) buffer_i (
    .clock        (clock),
    .reset        (reset),
    .flush        (redirect.valid),
    .packet       (packet),
    .packet_write (packet_write),
    .advance      (advance),
    .room         (room),
    .window       (window)
  );

  inst_decode #(
    .DECODE_WIDTH (DECODE_WIDTH)
  ) decode_i (
    .clock   (clock),
    .reset   (reset),
    .flush   (redirect.valid),
    .stall   (stall),
    .window  (window),
    .advance (advance),
    .uops    (uops)
  );

endmodule

`default_nettype wire

/* tb/decode_ref.svh */
// ====================
// reference decode for the RV32I subset, plus a random program word source
// random_inst draws from the $urandom stream of its caller
// ====================

`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

// expected micro-op for one instruction word at pc
function automatic micro_op_t decode_ref(input logic [31:0] inst, input logic [31:0] pc);
  micro_op_t          expected;
  logic signed [31:0] imm;
  logic               use_rs1;
  logic               use_rs2;
  logic               use_rd;

  expected        = '0;
  expected.valid  = 1'b1;
  expected.pc     = pc;
  expected.rs1    = inst[19:15];
  expected.rs2    = inst[24:20];
  expected.rd     = inst[11:7];
  expected.opcode = op_illegal;
  imm             = '0;
  use_rs1         = 1'b1;
  use_rs2         = 1'b0;
  use_rd          = 1'b1;
  case (inst[6:0])
    7'h33: begin
      use_rs2 = 1'b1;
      if (inst[31:25] == 7'h00) begin
        case (inst[14:12])
          3'd0: expected.opcode = op_add;
          3'd2: expected.opcode = op_slt;
          3'd4: expected.opcode = op_xor;
          3'd6: expected.opcode = op_or;
          3'd7: expected.opcode = op_and;
          default: ;
        endcase
      end else if (inst[31:25] == 7'h20 && inst[14:12] == 3'd0) begin
        expected.opcode = op_sub;
      end
    end
    7'h13: begin
      if (inst[14:12] == 3'd0) expected.opcode = op_addi;
      imm = $signed(inst) >>> 20;
    end
    7'h03: begin
      if (inst[14:12] == 3'd2) expected.opcode = op_load;
      imm = $signed(inst) >>> 20;
    end
    7'h37: begin
      expected.opcode = op_lui;
      use_rs1 = 1'b0;
      imm = {inst[31:12], 12'h000};
    end
    7'h23: begin
      if (inst[14:12] == 3'd2) expected.opcode = op_store;
      use_rs2 = 1'b1;
      use_rd  = 1'b0;
      imm = {inst[31:25], inst[11:7], 20'h0_0000};
      imm = imm >>> 20;
    end
    7'h63: begin
      if (inst[14:12] != 3'd2 && inst[14:12] != 3'd3) expected.opcode = op_branch;
      use_rs2 = 1'b1;
      use_rd  = 1'b0;
      imm = {inst[31], inst[7], inst[30:25], inst[11:8], 20'h0_0000};
      imm = imm >>> 19;
    end
    7'h6f: begin
      expected.opcode = op_jal;
      use_rs1 = 1'b0;
      imm = {inst[31], inst[19:12], inst[20], inst[30:21], 12'h000};
      imm = imm >>> 11;
    end
    default: ;
  endcase
  // illegal words carry no operands
  if (expected.opcode == op_illegal) begin
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    use_rd  = 1'b0;
    imm     = '0;
  end
  expected.rs1_valid = use_rs1;
  expected.rs2_valid = use_rs2;
  expected.rd_valid  = use_rd && (expected.rd != 5'd0);
  expected.imm       = imm;
  return expected;
endfunction

// one random word, every kept kind plus a few illegal flavours
function automatic logic [31:0] random_inst();
  logic [31:0] w;
  logic [2:0]  f3;

  w  = $urandom();
  f3 = w[14:12];
  case ($urandom_range(0, 11))
    0: begin
      if (f3 == 3'd1 || f3 == 3'd3 || f3 == 3'd5) f3 = 3'd0;
      w = {7'h00, w[24:15], f3, w[11:7], 7'h33};
    end
    1: w = {7'h20, w[24:15], 3'd0, w[11:7], 7'h33};
    2: w = {w[31:15], 3'd0, w[11:7], 7'h13};
    3: w = {w[31:7], 7'h37};
    4: w = {w[31:15], 3'd2, w[11:7], 7'h03};
    5: w = {w[31:15], 3'd2, w[11:7], 7'h23};
    6: begin
      if (f3 == 3'd2 || f3 == 3'd3) f3 = 3'd4;
      w = {w[31:15], f3, w[11:7], 7'h63};
    end
    7: w = {w[31:7], 7'h6f};
    // fence, system, auipc, jalr
    8: w[6:0] = (w[13:12] == 2'd0) ? 7'h0f : (w[13:12] == 2'd1) ? 7'h73 :
                (w[13:12] == 2'd2) ? 7'h17 : 7'h67;
    // mul is outside the subset
    9: w = {7'h01, w[24:15], f3, w[11:7], 7'h33};
    default: ;
  endcase
  return w;
endfunction

`endif

/* tb/frontend_tb.sv */
// ====================
// frontend with default parameters, program from random_inst in a word memory
// memory answers each line request after 0 to 3 cycles
// every micro-op is checked against decode_ref in pc order
// ====================

`default_nettype none

module frontend_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import frontend_pkg::*;

  `include "decode_ref.svh"

  localparam int          DECODE_WIDTH = 2;
  localparam int          FB_DEPTH     = 16;
  localparam logic [31:0] START_PC     = 32'h0000_1000;
  localparam int          CLOCK_PERIOD = 20;
  localparam int          MEM_WORDS    = 2048;
  localparam int          MEM_AW       = $clog2(MEM_WORDS);
  localparam int          DELAY_COUNT  = 256;
  localparam int unsigned SEED         = 60833;

  logic                         clock;
  logic                         reset;
  redirect_t                    redirect;
  logic [LINE_BITS-1:0]         icache_data;
  logic                         icache_valid;
  logic                         stall;
  logic [XLEN-1:0]              icache_addr;
  micro_op_t [DECODE_WIDTH-1:0] uops;

  logic [31:0] imem [MEM_WORDS];
  int unsigned delays [DELAY_COUNT];
  string       phase = "reset";
  int          error_count = 0;
  int          timeout_count = 0;
  int          checked_count = 0;
  int          illegal_count = 0;
  int          drop_count = 0;

  frontend #(
    .DECODE_WIDTH (DECODE_WIDTH),
    .FB_DEPTH     (FB_DEPTH),
    .RESET_PC     (START_PC)
  ) frontend_i (
    .clock        (clock),
    .reset        (reset),
    .redirect     (redirect),
    .icache_data  (icache_data),
    .icache_valid (icache_valid),
    .stall        (stall),
    .icache_addr  (icache_addr),
    .uops         (uops)
  );

  // memory wraps on the low address bits
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return imem[addr[MEM_AW+1:2]];
  endfunction

  function automatic logic [LINE_BITS-1:0] mem_line(input logic [31:0] addr);
    logic [LINE_BITS-1:0] data;
    for (int i = 0; i < FETCH_WIDTH; i++) begin
      data[i*XLEN +: XLEN] = mem_word(addr + 32'(4 * i));
    end
    return data;
  endfunction

  task automatic wait_uops(input int n, input int limit);
    int target;
    int cycles;
    target = checked_count + n;
    cycles = 0;
    while (checked_count < target && cycles < limit) begin
      @(negedge clock);
      cycles++;
    end
    if (checked_count < target) begin
      timeout_count++;
      $display("Timeout in %s: only %0d of %0d micro-ops arrived within %0d cycles",
               phase, n - (target - checked_count), n, limit);
    end
  endtask

  initial begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
  end

  // one response per request, delay taken from the table
  initial begin : memory_model
    int unsigned pick;
    pick         = 0;
    icache_valid = 1'b0;
    icache_data  = '0;
    forever begin
      @(negedge clock);
      icache_valid = 1'b0;
      repeat (delays[pick % DELAY_COUNT]) @(negedge clock);
      pick++;
      icache_data  = mem_line(icache_addr);
      icache_valid = 1'b1;
    end
  end

  initial begin : compare
    micro_op_t [DECODE_WIDTH-1:0] held;
    micro_op_t                    expected;
    logic [31:0]                  expected_pc;
    logic                         hold_check;
    logic [31:0]                  expected_addr;
    logic                         addr_check;
    held          = '0;
    expected_pc   = START_PC;
    hold_check    = 1'b0;
    expected_addr = '0;
    addr_check    = 1'b0;
    forever begin
      @(posedge clock);
      if (reset) begin
        expected_pc   = START_PC;
        hold_check    = 1'b0;
        // first request after reset is the aligned reset line
        expected_addr = START_PC & ~32'(LINE_BYTES - 1);
        addr_check    = 1'b1;
      end else begin
        if (addr_check && icache_addr !== expected_addr) begin
          error_count++;
          $display("Error: %s icache_addr expected %h actual %h",
                   phase, expected_addr, icache_addr);
        end
        if (hold_check && uops !== held) begin
          error_count++;
          $display("Error: %s stall hold expected %h actual %h", phase, held, uops);
        end
        // uops are taken downstream only at an edge without stall
        if (!stall) begin
          for (int i = 0; i < DECODE_WIDTH; i++) begin
            if (uops[i].valid) begin
              expected = decode_ref(mem_word(expected_pc), expected_pc);
              if (uops[i].pc !== expected_pc) begin
                error_count++;
                $display("Error: %s lane %0d pc expected %h actual %h",
                         phase, i, expected_pc, uops[i].pc);
              end else if (uops[i] !== expected) begin
                error_count++;
                $display("Error: %s lane %0d uop expected %h actual %h",
                         phase, i, expected, uops[i]);
              end
              if (uops[i] === expected && expected.opcode == op_illegal) illegal_count++;
              checked_count++;
              expected_pc = expected_pc + 32'd4;
            end
          end
        end
        if (icache_valid && !frontend_i.room && !redirect.valid) drop_count++;
        if (redirect.valid) expected_pc = redirect.pc;
        hold_check = stall && !redirect.valid;
        held       = uops;
        // a request stays put until the memory answers it
        addr_check    = !icache_valid && !redirect.valid;
        expected_addr = icache_addr;
      end
    end
  end

  initial begin : stimulus
    logic [31:0] target;
    int          drops_before;
    void'($urandom(SEED));
    reset    = 1'b1;
    stall    = 1'b0;
    redirect = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i] = random_inst();
    end
    for (int i = 0; i < DELAY_COUNT; i++) begin
      delays[i] = $urandom_range(0, 3);
    end
    repeat (10) @(negedge clock);
    reset = 1'b0;

    phase = "free run";
    wait_uops(64, 300);

    phase = "random stall";
    repeat (24) begin
      stall = 1'b1;
      repeat ($urandom_range(1, 8)) @(negedge clock);
      stall = 1'b0;
      repeat ($urandom_range(1, 4)) @(negedge clock);
    end
    wait_uops(32, 200);

    // targets sit mid-line, some arrive while stalled
    phase = "redirect";
    repeat (12) begin
      target = 32'($urandom_range(0, MEM_WORDS - 1)) << 2;
      if (target[3:2] == 2'b00) target[2] = 1'b1;
      stall          = ($urandom_range(0, 3) == 0);
      redirect.valid = 1'b1;
      redirect.pc    = target;
      @(negedge clock);
      redirect = '0;
      stall    = 1'b0;
      wait_uops(16, 150);
    end

    phase = "long stall";
    drops_before = drop_count;
    stall = 1'b1;
    repeat (48) @(negedge clock);
    stall = 1'b0;
    if (drop_count == drops_before) begin
      error_count++;
      $display("Long stall never filled the fetch buffer, no response was dropped");
    end
    wait_uops(48, 300);

    if (illegal_count == 0) begin
      error_count++;
      $display("No illegal instruction reached the decoder output");
    end
    $display("errors: %0d check failures, %0d timeouts, %0d micro-ops checked, %0d drops",
             error_count, timeout_count, checked_count, drop_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* frontend.f */
+incdir+tb
hdl/frontend_pkg.sv
hdl/inst_fetch.sv
hdl/fetch_buffer.sv
hdl/inst_decode.sv
hdl/frontend.sv
tb/frontend_tb.sv
